// ==== src.f ====
+incdir+src
src/pcie_pkg.sv
src/meta_fifo.sv
src/rx_meta_ctrl.sv
src/pkt_queue_manager.sv
src/ordered_meta_mux.sv
src/pcie_rx_top.sv
dv/pcie_rx_checker.sv
dv/pcie_rx_tb.sv

// ==== Bender.yml ====
package:
  name: pcie_rx

sources:
  - include_dirs:
      - src
    files:
      - src/pcie_pkg.sv
      - src/meta_fifo.sv
      - src/rx_meta_ctrl.sv
      - src/pkt_queue_manager.sv
      - src/ordered_meta_mux.sv
      - src/pcie_rx_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/pcie_rx_checker.sv
      - dv/pcie_rx_tb.sv

// ==== dv/pcie_rx_tb.sv ====
`include "pcie_consts.svh"

module pcie_rx_tb
    import pcie_pkg::*;
();

localparam int CLK_PERIOD      = 100;
localparam int RESET_CYCLES    = 10;
localparam int CTRL_CYCLES     = 16;
localparam int TRAFFIC_CYCLES  = 2000;
localparam int HEAD_CYCLES     = 800;
localparam int BURST_CYCLES    = 40;
localparam int MERGE_CYCLES    = 1000;
localparam int DRAIN_LIMIT     = 500;
localparam int TEST_BUDGET     = CTRL_CYCLES + TRAFFIC_CYCLES + HEAD_CYCLES +
    BURST_CYCLES + MERGE_CYCLES + 5 * DRAIN_LIMIT;
localparam int WATCHDOG_CYCLES = TEST_BUDGET * 4 + 1000;

logic         pcie_clk;
logic         pcie_reset_n;
mmio_wr_t     mmio_wr;
pkt_meta_t    rx_meta;
logic         rx_meta_valid;
logic         rx_meta_ready;
queued_meta_t meta_out;
logic         meta_out_valid;
logic         meta_out_ready;
logic         sw_reset;
logic [31:0]  rx_ignored_head_cnt;
logic [31:0]  merged_meta_cnt;
logic         check_counts_req;
logic         check_stall_req;
logic         drained;
int           checker_errors;
int           tb_errors;
int           errors_seen;
int           passed_tests;
int           failed_tests;
rb_ptr_t      rb_size;

pcie_rx_top i_pcie_rx_top (.*);

pcie_rx_checker i_pcie_rx_checker (.*, .error_cnt (checker_errors));

initial begin
    pcie_clk = 1'b0;
end

always #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;

function automatic mmio_wr_t build_write(input int page, input logic [7:0] be,
                                         input logic [63:0] data);
    mmio_wr_t wr;
    wr = '0;
    wr.valid      = 1'b1;
    wr.address    = `PCIE_ADDR_WIDTH'(page) << `PCIE_PAGE_LSB;
    wr.byteenable = be;
    wr.writedata  = data;
    return wr;
endfunction

function automatic logic [63:0] ctrl_word(input rb_ptr_t size, input logic reset_req);
    logic [63:0] data;
    data = '0;
    data[`PCIE_CTRL_RB_SIZE_LSB +: `PCIE_RB_AWIDTH+1] = size;
    data[`PCIE_CTRL_SW_RESET_BIT] = reset_req;
    return data;
endfunction

// Full head writes, partial ones that miss the head register, and writes to unused pages.
function automatic mmio_wr_t random_write();
    int         page;
    logic [7:0] be;
    case ($urandom % 4)
        0, 1: begin
            page = $urandom % `PCIE_MAX_NB_FLOWS;
            be = ($urandom % 2) ? 8'hff : 8'hf0;
        end
        2: begin
            page = $urandom % `PCIE_MAX_NB_FLOWS;
            be = {1'b0, 7'($urandom)};
        end
        default: begin
            page = `PCIE_MAX_NB_FLOWS + $urandom % 15;
            be = 8'hff;
        end
    endcase
    return build_write(page, be, {$urandom, $urandom});
endfunction

task automatic drive_cycle(input int rx_pct, input int ready_pct);
    logic taken;
    @(negedge pcie_clk);
    taken = rx_meta_valid && rx_meta_ready;
    @(posedge pcie_clk);
    if (!rx_meta_valid || taken) begin
        rx_meta_valid <= ($urandom % 100) < rx_pct;
        rx_meta.pkt_queue_id <= flow_id_t'($urandom % `PCIE_MAX_NB_FLOWS);
        rx_meta.size <= rb_ptr_t'(1 + $urandom % 40);
    end
    meta_out_ready <= ($urandom % 100) < ready_pct;
    mmio_wr <= '0;
endtask

task automatic run_random_traffic(input int cycles, input int rx_pct, input int mmio_pct,
                                  input int ready_pct);
    repeat (cycles) begin
        drive_cycle(rx_pct, ready_pct);
        if (($urandom % 100) < mmio_pct) begin
            mmio_wr <= random_write();
        end
    end
endtask

task automatic drain_and_check();
    int waited;
    waited = 0;
    drive_cycle(0, 100);
    while (!drained && waited < DRAIN_LIMIT) begin
        drive_cycle(0, 100);
        waited++;
    end
    if (!drained) begin
        $display("Items still in flight %0d cycles after the stimulus stopped", DRAIN_LIMIT);
        tb_errors++;
    end
    check_counts_req <= 1'b1;
    drive_cycle(0, 100);
    check_counts_req <= 1'b0;
    drive_cycle(0, 100);
endtask

task automatic report_test(input string name);
    int errs;
    errs = checker_errors + tb_errors;
    if (errs == errors_seen) begin
        passed_tests++;
        $display("Test %-16s PASS", name);
    end else begin
        failed_tests++;
        $display("Test %-16s FAIL with %0d errors", name, errs - errors_seen);
    end
    errors_seen = errs;
endtask

initial begin
    void'($urandom(32'h16dc_cd8b));
    pcie_reset_n = 1'b0;
    mmio_wr = '0;
    rx_meta = '0;
    rx_meta_valid = 1'b0;
    meta_out_ready = 1'b0;
    check_counts_req = 1'b0;
    check_stall_req = 1'b0;
    {tb_errors, errors_seen, passed_tests, failed_tests} = '0;
    repeat (RESET_CYCLES) @(posedge pcie_clk);
    pcie_reset_n <= 1'b1;

    // A small ring makes the tails wrap often in the traffic tests.
    rb_size = rb_ptr_t'(48 + $urandom % 200);
    drive_cycle(0, 100);
    mmio_wr <= build_write(`PCIE_CTRL_PAGE, 8'h0f, ctrl_word(rb_size, 1'b1));
    repeat (CTRL_CYCLES / 2) drive_cycle(0, 100);
    mmio_wr <= build_write(`PCIE_CTRL_PAGE, 8'hff, ctrl_word(rb_size, 1'b0));
    repeat (CTRL_CYCLES / 2) drive_cycle(0, 100);
    drain_and_check();
    report_test("ctrl_write");

    run_random_traffic(TRAFFIC_CYCLES, 60, 10, 70);
    drain_and_check();
    report_test("queue_tails");

    run_random_traffic(HEAD_CYCLES, 30, 60, 90);
    drain_and_check();
    report_test("head_accounting");

    drive_cycle(0, 0);
    repeat (BURST_CYCLES) begin
        drive_cycle(100, 0);
        mmio_wr <= build_write($urandom % `PCIE_MAX_NB_FLOWS, 8'hf0, {$urandom, $urandom});
    end
    drive_cycle(0, 0);
    check_stall_req <= 1'b1;
    drive_cycle(0, 0);
    check_stall_req <= 1'b0;
    drain_and_check();
    report_test("overflow");

    run_random_traffic(MERGE_CYCLES, 70, 20, 50);
    drain_and_check();
    report_test("merge_count");

    $display("Tests: %0d passed, %0d failed, %0d errors in total",
        passed_tests, failed_tests, checker_errors + tb_errors);
    if (failed_tests == 0 && checker_errors + tb_errors == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge pcie_clk);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
end

endmodule

// ==== dv/pcie_rx_checker.sv ====
`include "pcie_consts.svh"

module pcie_rx_checker
    import pcie_pkg::*;
(
    input  logic         pcie_clk,
    input  logic         pcie_reset_n,
    input  mmio_wr_t     mmio_wr,
    input  pkt_meta_t    rx_meta,
    input  logic         rx_meta_valid,
    input  logic         rx_meta_ready,
    input  queued_meta_t meta_out,
    input  logic         meta_out_valid,
    input  logic         meta_out_ready,
    input  logic         sw_reset,
    input  logic [31:0]  rx_ignored_head_cnt,
    input  logic [31:0]  merged_meta_cnt,
    input  logic         check_counts_req,
    input  logic         check_stall_req,
    output int           error_cnt,
    output logic         drained
);

rb_ptr_t                          size_q [`PCIE_MAX_NB_FLOWS][$];
rb_ptr_t                          model_tail [`PCIE_MAX_NB_FLOWS];
rb_ptr_t                          rb_size;
logic [2:0]                       sw_reset_pipe;
int                               pkt_pending;
int unsigned                      rx_accepted;
int unsigned                      head_writes;
int unsigned                      desc_seen;
logic [31:0]                      ignored_mark;
logic [`PCIE_TABLE_IDX_WIDTH-1:0] page;

assign page = mmio_wr.address[`PCIE_PAGE_LSB +: `PCIE_TABLE_IDX_WIDTH];

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        error_cnt++;
    end
endtask

// Outputs of one queue come in merge order, so the model tail is exact.
task automatic check_output(input queued_meta_t m);
    int unsigned                q;
    rb_ptr_t                    exp_size;
    logic [`PCIE_RB_AWIDTH+1:0] sum;
    q = m.pkt_queue_id;
    exp_size = '0;
    if (!m.descriptor_only && size_q[q].size() == 0) begin
        $display("Packet output for queue %0d has no matching accepted input", q);
        error_cnt++;
        return;
    end
    if (m.descriptor_only) begin
        desc_seen++;
    end else begin
        exp_size = size_q[q].pop_front();
        pkt_pending--;
    end
    compare($sformatf("meta_out.size (queue %0d)", q), m.size, exp_size);
    compare($sformatf("meta_out.tail (queue %0d)", q), m.tail, model_tail[q]);
    sum = model_tail[q] + exp_size;
    model_tail[q] = (sum >= rb_size) ? rb_ptr_t'(sum - rb_size) : rb_ptr_t'(sum);
endtask

task automatic check_counts();
    compare("rx_ignored_head_cnt", rx_ignored_head_cnt, head_writes - desc_seen);
    compare("merged_meta_cnt", merged_meta_cnt, rx_accepted + desc_seen);
    if (pkt_pending != 0) begin
        $display("%0d accepted packets never reached meta_out", pkt_pending);
        error_cnt++;
    end
    ignored_mark = rx_ignored_head_cnt;
endtask

task automatic check_stall();
    if (rx_ignored_head_cnt <= ignored_mark) begin
        $display("No head write was ignored while the head-update queue was full");
        error_cnt++;
    end
    if (rx_meta_ready) begin
        $display("rx_meta_ready stayed high while meta_out was stalled");
        error_cnt++;
    end
endtask

always @(negedge pcie_clk) begin
    if (!pcie_reset_n) begin
        for (int i = 0; i < `PCIE_MAX_NB_FLOWS; i++) begin
            size_q[i].delete();
            model_tail[i] = '0;
        end
        rb_size = rb_ptr_t'(`PCIE_PKT_RB_SIZE_RST);
        sw_reset_pipe = '0;
        {pkt_pending, rx_accepted, head_writes, desc_seen} = '0;
        ignored_mark = '0;
        error_cnt = 0;
        drained = 1'b0;
    end else begin
        // The request bit reaches sw_reset through the register and two sync stages.
        compare("sw_reset", sw_reset, sw_reset_pipe[2]);
        sw_reset_pipe[2:1] = sw_reset_pipe[1:0];
        if (mmio_wr.valid && page == `PCIE_CTRL_PAGE && mmio_wr.byteenable[3:0] == 4'hf) begin
            rb_size = mmio_wr.writedata[`PCIE_CTRL_RB_SIZE_LSB +: `PCIE_RB_AWIDTH+1];
            sw_reset_pipe[0] = mmio_wr.writedata[`PCIE_CTRL_SW_RESET_BIT];
        end
        if (mmio_wr.valid && page < `PCIE_MAX_NB_FLOWS && mmio_wr.byteenable[7:4] == 4'hf) begin
            head_writes++;
        end
        if (rx_meta_valid && rx_meta_ready) begin
            size_q[rx_meta.pkt_queue_id].push_back(rx_meta.size);
            pkt_pending++;
            rx_accepted++;
        end
        if (meta_out_valid && meta_out_ready) begin
            check_output(meta_out);
        end
        if (check_counts_req) begin
            check_counts();
        end
        if (check_stall_req) begin
            check_stall();
        end
        drained = !rx_meta_valid && !meta_out_valid && pkt_pending == 0 &&
            merged_meta_cnt == rx_accepted + desc_seen &&
            head_writes == desc_seen + rx_ignored_head_cnt;
    end
end

endmodule

// ==== src/pcie_rx_top.sv ====
`include "pcie_consts.svh"

module pcie_rx_top
    import pcie_pkg::*;
(
    input  logic         pcie_clk,
    input  logic         pcie_reset_n,
    input  mmio_wr_t     mmio_wr,
    input  pkt_meta_t    rx_meta,
    input  logic         rx_meta_valid,
    output logic         rx_meta_ready,
    output queued_meta_t meta_out,
    output logic         meta_out_valid,
    input  logic         meta_out_ready,
    output logic         sw_reset,
    output logic [31:0]  rx_ignored_head_cnt,
    output logic [31:0]  merged_meta_cnt
);

flow_id_t                                 head_push_data;
logic                                     head_push_valid;
logic [$clog2(`PCIE_HEAD_UPD_QUEUE_LEN):0] head_occup;
flow_id_t                                 head_pop_data;
logic                                     head_pop_valid;
logic                                     head_pop_ready;

queued_meta_t                             inq_push_data;
logic                                     inq_push_valid;
logic [$clog2(`PCIE_IN_QUEUE_LEN):0]       inq_occup;
queued_meta_t                             inq_pop_data;
logic                                     inq_pop_valid;
logic                                     inq_pop_ready;

logic [`PCIE_NB_PKT_QM-1:0]               qm_valid;
queued_meta_t                             qm_data;
logic [`PCIE_NB_PKT_QM-1:0]               qm_ready;
queued_meta_t                             qm_out_meta [`PCIE_NB_PKT_QM];
logic [`PCIE_NB_PKT_QM-1:0]               qm_out_valid;
logic [`PCIE_NB_PKT_QM-1:0]               qm_out_ready;

logic                                     order_valid;
qm_id_t                                   order_id;
logic                                     order_ready;
ctrl_reg_t                                ctrl;

rx_meta_ctrl rx_meta_ctrl_inst (
    .pcie_clk (pcie_clk), .pcie_reset_n (pcie_reset_n),
    .mmio_wr (mmio_wr), .rx_meta (rx_meta),
    .rx_meta_valid (rx_meta_valid), .rx_meta_ready (rx_meta_ready),
    .head_push_data (head_push_data), .head_push_valid (head_push_valid),
    .head_occup (head_occup), .head_pop_data (head_pop_data),
    .head_pop_valid (head_pop_valid), .head_pop_ready (head_pop_ready),
    .inq_push_data (inq_push_data), .inq_push_valid (inq_push_valid),
    .inq_occup (inq_occup), .inq_pop_data (inq_pop_data),
    .inq_pop_valid (inq_pop_valid), .inq_pop_ready (inq_pop_ready),
    .qm_valid (qm_valid), .qm_data (qm_data), .qm_ready (qm_ready),
    .order_valid (order_valid), .order_id (order_id), .order_ready (order_ready),
    .ctrl (ctrl), .sw_reset (sw_reset),
    .rx_ignored_head_cnt (rx_ignored_head_cnt), .merged_meta_cnt (merged_meta_cnt)
);

meta_fifo #(.payload_t (flow_id_t), .DEPTH (`PCIE_HEAD_UPD_QUEUE_LEN)) head_upd_queue (
    .pcie_clk (pcie_clk), .pcie_reset_n (pcie_reset_n),
    .in_data (head_push_data), .in_valid (head_push_valid), .in_ready (),
    .out_data (head_pop_data), .out_valid (head_pop_valid), .out_ready (head_pop_ready),
    .occup (head_occup)
);

meta_fifo #(.payload_t (queued_meta_t), .DEPTH (`PCIE_IN_QUEUE_LEN)) in_queue (
    .pcie_clk (pcie_clk), .pcie_reset_n (pcie_reset_n),
    .in_data (inq_push_data), .in_valid (inq_push_valid), .in_ready (),
    .out_data (inq_pop_data), .out_valid (inq_pop_valid), .out_ready (inq_pop_ready),
    .occup (inq_occup)
);

for (genvar i = 0; i < `PCIE_NB_PKT_QM; i++) begin : gen_pqm
    pkt_queue_manager #(
        .NB_QUEUES (`PCIE_MAX_NB_FLOWS / `PCIE_NB_PKT_QM)
    ) pkt_queue_manager_inst (
        .pcie_clk (pcie_clk), .pcie_reset_n (pcie_reset_n),
        .pkt_rb_size (ctrl.pkt_rb_size),
        .in_meta (qm_data), .in_valid (qm_valid[i]), .in_ready (qm_ready[i]),
        .out_meta (qm_out_meta[i]), .out_valid (qm_out_valid[i]),
        .out_ready (qm_out_ready[i])
    );
end

ordered_meta_mux #(.NB_IN (`PCIE_NB_PKT_QM)) ordered_meta_mux_inst (
    .pcie_clk (pcie_clk), .pcie_reset_n (pcie_reset_n),
    .in_meta (qm_out_meta), .in_valid (qm_out_valid), .in_ready (qm_out_ready),
    .order_id (order_id), .order_valid (order_valid), .order_ready (order_ready),
    .out_meta (meta_out), .out_valid (meta_out_valid), .out_ready (meta_out_ready)
);

endmodule

// ==== src/ordered_meta_mux.sv ====
`include "pcie_consts.svh"

module ordered_meta_mux
    import pcie_pkg::*;
#(
    parameter  int NB_IN = 2,
    localparam int SEL_WIDTH = $clog2(NB_IN)
) (
    input  logic                 pcie_clk,
    input  logic                 pcie_reset_n,
    input  queued_meta_t         in_meta [NB_IN],
    input  logic [NB_IN-1:0]     in_valid,
    output logic [NB_IN-1:0]     in_ready,
    input  logic [SEL_WIDTH-1:0] order_id,
    input  logic                 order_valid,
    output logic                 order_ready,
    output queued_meta_t         out_meta,
    output logic                 out_valid,
    input  logic                 out_ready
);

logic [SEL_WIDTH-1:0] head_sel;
logic                 head_valid;
logic                 head_pop;

// Each entry names the manager that holds the next item in merge order.
meta_fifo #(
    .payload_t (logic [SEL_WIDTH-1:0]),
    .DEPTH     (2*NB_IN)
) order_fifo (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (order_id),
    .in_valid     (order_valid),
    .in_ready     (order_ready),
    .out_data     (head_sel),
    .out_valid    (head_valid),
    .out_ready    (head_pop),
    .occup        ()
);

// Other managers may already hold items, but they wait for their turn.
assign out_meta  = in_meta[head_sel];
assign out_valid = head_valid && in_valid[head_sel];
assign head_pop  = out_valid && out_ready;

always_comb begin
    for (int i = 0; i < NB_IN; i++) begin
        in_ready[i] = head_valid && (head_sel == i) && out_ready;
    end
end

endmodule

// ==== src/pkt_queue_manager.sv ====
`include "pcie_consts.svh"

module pkt_queue_manager
    import pcie_pkg::*;
#(
    parameter int NB_QUEUES = 8
) (
    input  logic         pcie_clk,
    input  logic         pcie_reset_n,
    input  rb_ptr_t      pkt_rb_size,
    input  queued_meta_t in_meta,
    input  logic         in_valid,
    output logic         in_ready,
    output queued_meta_t out_meta,
    output logic         out_valid,
    input  logic         out_ready
);

localparam int IDX_WIDTH = $clog2(NB_QUEUES);

rb_ptr_t                  tails [NB_QUEUES];
logic [IDX_WIDTH-1:0]     q_idx;
rb_ptr_t                  cur_tail;
logic [`PCIE_RB_AWIDTH+1:0] tail_sum;
logic [`PCIE_RB_AWIDTH+1:0] tail_wrap;
rb_ptr_t                  next_tail;
logic                     accept;

// The low id bits already chose this manager, the rest index its table.
assign q_idx    = in_meta.pkt_queue_id[`PCIE_QM_ID_WIDTH +: IDX_WIDTH];
assign cur_tail = tails[q_idx];

assign tail_sum  = cur_tail + in_meta.size;
assign tail_wrap = tail_sum - pkt_rb_size;

always_comb begin
    if (tail_sum >= pkt_rb_size) begin
        next_tail = tail_wrap[`PCIE_RB_AWIDTH:0];
    end else begin
        next_tail = tail_sum[`PCIE_RB_AWIDTH:0];
    end
end

assign in_ready = !out_valid || out_ready;
assign accept   = in_valid && in_ready;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        for (int i = 0; i < NB_QUEUES; i++) begin
            tails[i] <= '0;
        end
        out_valid <= 1'b0;
    end else begin
        if (accept) begin
            out_valid <= 1'b1;
            // A descriptor-only item reports the tail but does not move it.
            if (!in_meta.descriptor_only) begin
                tails[q_idx] <= next_tail;
            end
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (accept) begin
        out_meta      <= in_meta;
        out_meta.tail <= cur_tail;
    end
end

// A packet as large as the ring would wrap onto itself.
a_size_fits_ring: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    (accept && !in_meta.descriptor_only) |-> (in_meta.size < pkt_rb_size)
);

endmodule

// ==== src/rx_meta_ctrl.sv ====
`include "pcie_consts.svh"

module rx_meta_ctrl
    import pcie_pkg::*;
(
    input  logic                                    pcie_clk,
    input  logic                                    pcie_reset_n,
    input  mmio_wr_t                                mmio_wr,
    input  pkt_meta_t                               rx_meta,
    input  logic                                    rx_meta_valid,
    output logic                                    rx_meta_ready,

    output flow_id_t                                head_push_data,
    output logic                                    head_push_valid,
    input  logic [$clog2(`PCIE_HEAD_UPD_QUEUE_LEN):0] head_occup,
    input  flow_id_t                                head_pop_data,
    input  logic                                    head_pop_valid,
    output logic                                    head_pop_ready,

    output queued_meta_t                            inq_push_data,
    output logic                                    inq_push_valid,
    input  logic [$clog2(`PCIE_IN_QUEUE_LEN):0]      inq_occup,
    input  queued_meta_t                            inq_pop_data,
    input  logic                                    inq_pop_valid,
    output logic                                    inq_pop_ready,

    output logic [`PCIE_NB_PKT_QM-1:0]              qm_valid,
    output queued_meta_t                            qm_data,
    input  logic [`PCIE_NB_PKT_QM-1:0]              qm_ready,

    output logic                                    order_valid,
    output qm_id_t                                  order_id,
    input  logic                                    order_ready,

    output ctrl_reg_t                               ctrl,
    output logic                                    sw_reset,
    output logic [31:0]                             rx_ignored_head_cnt,
    output logic [31:0]                             merged_meta_cnt
);

logic [`PCIE_TABLE_IDX_WIDTH-1:0] page;
logic                             head_wr;
logic                             ctrl_wr;
logic                             head_almost_full;
logic                             inq_almost_full;
logic                             head_fire;
logic                             rx_fire;
queued_meta_t                     merge_data;
qm_id_t                           qm_sel;
logic                             steer_fire;
logic                             sw_reset_meta;

assign page = mmio_wr.address[`PCIE_PAGE_LSB +: `PCIE_TABLE_IDX_WIDTH];

// Only a write covering the whole head register counts as a head update.
assign head_wr = mmio_wr.valid && (page < `PCIE_MAX_NB_FLOWS) &&
    (mmio_wr.byteenable[`PCIE_HEAD_REG*`PCIE_REG_SIZE +: `PCIE_REG_SIZE] == '1);
assign ctrl_wr = mmio_wr.valid && (page == `PCIE_CTRL_PAGE) &&
    (mmio_wr.byteenable[0 +: `PCIE_REG_SIZE] == '1);

assign head_almost_full =
    head_occup > (`PCIE_HEAD_UPD_QUEUE_LEN - `PCIE_HEAD_UPD_SLACK);
assign inq_almost_full = inq_occup > `PCIE_IN_QUEUE_THRESH;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        head_push_valid     <= 1'b0;
        rx_ignored_head_cnt <= '0;
    end else begin
        head_push_valid <= head_wr && !head_almost_full;
        if (head_wr && head_almost_full) begin
            rx_ignored_head_cnt <= rx_ignored_head_cnt + 1'b1;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    head_push_data <= page[`PCIE_FLOW_IDX_WIDTH-1:0];
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        ctrl.pkt_rb_size  <= rb_ptr_t'(`PCIE_PKT_RB_SIZE_RST);
        ctrl.sw_reset_req <= 1'b0;
        sw_reset_meta     <= 1'b0;
        sw_reset          <= 1'b0;
    end else begin
        if (ctrl_wr) begin
            ctrl.pkt_rb_size <=
                mmio_wr.writedata[`PCIE_CTRL_RB_SIZE_LSB +: `PCIE_RB_AWIDTH+1];
            ctrl.sw_reset_req <= mmio_wr.writedata[`PCIE_CTRL_SW_RESET_BIT];
        end
        sw_reset_meta <= ctrl.sw_reset_req;
        sw_reset      <= sw_reset_meta;
    end
end

// Head updates go first. Injecting them here, and not in the managers,
// keeps descriptor-only items ordered against the packets around them.
assign head_pop_ready = !inq_almost_full;
assign rx_meta_ready  = !inq_almost_full && !head_pop_valid;
assign head_fire      = head_pop_valid && head_pop_ready;
assign rx_fire        = rx_meta_valid && rx_meta_ready;

always_comb begin
    merge_data = '0;
    if (head_pop_valid) begin
        merge_data.pkt_queue_id    = head_pop_data;
        merge_data.descriptor_only = 1'b1;
    end else begin
        merge_data.pkt_queue_id = rx_meta.pkt_queue_id;
        merge_data.size         = rx_meta.size;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        inq_push_valid  <= 1'b0;
        merged_meta_cnt <= '0;
    end else begin
        inq_push_valid <= head_fire || rx_fire;
        if (head_fire || rx_fire) begin
            merged_meta_cnt <= merged_meta_cnt + 1'b1;
        end
    end
end

always_ff @(posedge pcie_clk) begin
    inq_push_data <= merge_data;
end

// The low queue-id bits pick the manager.
assign qm_sel        = inq_pop_data.pkt_queue_id[`PCIE_QM_ID_WIDTH-1:0];
assign inq_pop_ready = qm_ready[qm_sel] && order_ready;
assign steer_fire    = inq_pop_valid && inq_pop_ready;
assign qm_valid      = {{(`PCIE_NB_PKT_QM-1){1'b0}}, steer_fire} << qm_sel;
assign qm_data       = inq_pop_data;
assign order_valid   = steer_fire;
assign order_id      = qm_sel;

// A packet offered while the merge is busy must wait unchanged.
a_rx_meta_held: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    (rx_meta_valid && !rx_meta_ready) |=> (rx_meta_valid && $stable(rx_meta))
);

endmodule

// ==== src/meta_fifo.sv ====
module meta_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic                  pcie_clk,
    input  logic                  pcie_reset_n,
    input  payload_t              in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output payload_t              out_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [$clog2(DEPTH):0] occup
);

localparam int PTR_WIDTH = $clog2(DEPTH);

payload_t mem [DEPTH];

logic [PTR_WIDTH-1:0] wr_ptr;
logic [PTR_WIDTH-1:0] rd_ptr;
logic                 push;
logic                 pop;

assign in_ready  = occup < DEPTH;
assign out_valid = occup != 0;
assign out_data  = mem[rd_ptr];

assign push = in_valid && in_ready;
assign pop  = out_valid && out_ready;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        occup  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        occup <= occup + push - pop;
    end
end

always_ff @(posedge pcie_clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
end

// Writers throttle on occupancy well before the FIFO fills, so an offer
// while full means the upstream threshold logic is broken.
a_no_push_when_full: assert property (
    @(posedge pcie_clk) disable iff (!pcie_reset_n)
    in_valid |-> in_ready
);

endmodule

// ==== src/pcie_pkg.sv ====
`include "pcie_consts.svh"

package pcie_pkg;

typedef logic [`PCIE_FLOW_IDX_WIDTH-1:0] flow_id_t;
typedef logic [`PCIE_QM_ID_WIDTH-1:0] qm_id_t;
typedef logic [`PCIE_RB_AWIDTH:0] rb_ptr_t;

// One host write, presented for a single cycle.
typedef struct packed {
    logic                                  valid;
    logic [`PCIE_ADDR_WIDTH-1:0]           address;
    logic [`PCIE_MMIO_DATA_WIDTH/8-1:0]    byteenable;
    logic [`PCIE_MMIO_DATA_WIDTH-1:0]      writedata;
} mmio_wr_t;

typedef struct packed {
    flow_id_t pkt_queue_id;
    rb_ptr_t  size;
} pkt_meta_t;

// Metadata after the merge. The tail is filled in by the queue manager.
typedef struct packed {
    flow_id_t pkt_queue_id;
    rb_ptr_t  size;
    logic     descriptor_only;
    rb_ptr_t  tail;
} queued_meta_t;

typedef struct packed {
    rb_ptr_t pkt_rb_size;
    logic    sw_reset_req;
} ctrl_reg_t;

endpackage

// ==== src/pcie_consts.svh ====
`ifndef PCIE_CONSTS_SVH
`define PCIE_CONSTS_SVH

// Packet queue managers and the queues they share.
`define PCIE_NB_PKT_QM 2
`define PCIE_QM_ID_WIDTH 1
`define PCIE_MAX_NB_FLOWS 16
`define PCIE_FLOW_IDX_WIDTH 4

// MMIO decode. Each queue owns a 4 KB page and the head is register 1 of it.
`define PCIE_ADDR_WIDTH 20
`define PCIE_TABLE_IDX_WIDTH 5
`define PCIE_PAGE_LSB 12
`define PCIE_MMIO_DATA_WIDTH 64
`define PCIE_REG_SIZE 4
`define PCIE_HEAD_REG 1
`define PCIE_CTRL_PAGE 31
`define PCIE_CTRL_RB_SIZE_LSB 1
`define PCIE_CTRL_SW_RESET_BIT 27

// Ring-buffer pointers are one bit wider than the address width.
`define PCIE_RB_AWIDTH 10
`define PCIE_PKT_RB_SIZE_RST 512

// Queue depths and the levels where the merge backs off.
`define PCIE_HEAD_UPD_QUEUE_LEN 16
`define PCIE_HEAD_UPD_SLACK 4
`define PCIE_IN_QUEUE_LEN 8
`define PCIE_IN_QUEUE_THRESH 4

`endif
